//--- verification/cpu_core_vectors.txt
# Lines I addr word load the program, with byte address and instruction in hex.
# Lines W rd data give the writebacks in retirement order, with rd and data in hex.
I 00000000 00500093 # addi x1, x0, 5
I 00000004 FFD00113 # addi x2, x0, -3
I 00000008 002081B3 # add  x3, x1, x2
I 0000000C 40110233 # sub  x4, x2, x1
I 00000010 403252B3 # sra  x5, x4, x3
I 00000014 00122333 # slt  x6, x4, x1
I 00000018 0040A3B3 # slt  x7, x1, x4
I 0000001C 01C25413 # srli x8, x4, 28
I 00000020 40125493 # srai x9, x4, 1
I 00000024 00409513 # slli x10, x1, 4
I 00000028 FFF0C593 # xori x11, x1, -1
I 0000002C 00A1E633 # or   x12, x3, x10
I 00000030 002676B3 # and  x13, x12, x2
I 00000034 0016C733 # xor  x14, x13, x1
I 00000038 123457B7 # lui  x15, 0x12345
I 0000003C 67878793 # addi x15, x15, 0x678
I 00000040 00708013 # addi x0, x1, 7
I 00000044 00100833 # add  x16, x0, x1
I 00000048 00C008EF # jal  x17, +12
I 0000004C 00100913 # addi x18, x0, 1 (skipped by jal)
I 00000050 00200913 # addi x18, x0, 2 (skipped by jal)
I 00000054 01008663 # beq  x1, x16, +12 (taken)
I 00000058 00100993 # addi x19, x0, 1 (flushed)
I 0000005C 00200993 # addi x19, x0, 2 (flushed)
I 00000060 01009663 # bne  x1, x16, +12 (not taken)
I 00000064 00900A13 # addi x20, x0, 9
I 00000068 01424663 # blt  x4, x20, +12 (taken)
I 0000006C 00100A93 # addi x21, x0, 1 (flushed)
I 00000070 00200A93 # addi x21, x0, 2 (flushed)
I 00000074 00111663 # bne  x2, x1, +12 (taken)
I 00000078 00100B13 # addi x22, x0, 1 (flushed)
I 0000007C 00200B13 # addi x22, x0, 2 (flushed)
I 00000080 001A0B93 # addi x23, x20, 1
I 00000084 00000073 # ecall
I 00000088 00100C13 # addi x24, x0, 1 (after halt)
W 01 00000005
W 02 FFFFFFFD
W 03 00000002
W 04 FFFFFFF8
W 05 FFFFFFFE
W 06 00000001
W 07 00000000
W 08 0000000F
W 09 FFFFFFFC
W 0A 00000050
W 0B FFFFFFFA
W 0C 00000052
W 0D 00000050
W 0E 00000055
W 0F 12345000
W 0F 12345678
W 10 00000005
W 11 0000004C
W 14 00000009
W 17 0000000A

//--- tb.f
+incdir+design
design/cpu_pkg.sv
design/fetch_decode_stage.sv
design/register_file.sv
design/execute_stage.sv
design/writeback_stage.sv
design/pipeline_control.sv
design/cpu_core.sv
verification/cpu_core_tb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - design
    files:
      - design/cpu_pkg.sv
      - design/fetch_decode_stage.sv
      - design/register_file.sv
      - design/execute_stage.sv
      - design/writeback_stage.sv
      - design/pipeline_control.sv
      - design/cpu_core.sv
  - target: simulation
    files:
      - verification/cpu_core_tb.sv

//--- verification/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb import cpu_pkg::*; ();

  localparam int MEM_WORDS = 64;
  localparam int HALT_TIMEOUT = 500;
  localparam int DRAIN_CYCLES = 10;

  logic clk;
  logic reset;
  addr_t imem_addr;
  inst_t imem_inst;
  logic wb_valid;
  reg_idx_t wb_rd;
  word_t wb_data;
  logic halted;

  // Program image, word indexed.
  inst_t mem [0:MEM_WORDS-1];

  // Expected writebacks in retirement order.
  reg_idx_t exp_rd [$];
  word_t exp_data [$];

  int expected_total;
  int retired;
  int mismatches;
  int errors;

  cpu_core cpu_core_inst (
    .clk(clk),
    .reset(reset),
    .imem_addr(imem_addr),
    .imem_inst(imem_inst),
    .wb_valid(wb_valid),
    .wb_rd(wb_rd),
    .wb_data(wb_data),
    .halted(halted)
  );

  // 8 ns clock.
  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // Instruction memory with a one-cycle read.
  always @(posedge clk) begin
    imem_inst <= mem[imem_addr[7:2]];
  end

  // Unused words hold a custom-0 opcode, which retires as a no-op.
  task automatic fill_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {i[24:0], 7'b0001011};
    end
  endtask

  // Parse program words and expected writebacks.
  task automatic load_vectors();
    int fd;
    int n;
    string line;
    byte kind;
    logic [31:0] a;
    logic [31:0] b;
    fd = $fopen("verification/cpu_core_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open verification/cpu_core_vectors.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // Lines starting with # are comments.
      if (n > 0 && line[0] != "#") begin
        n = $sscanf(line, "%c %h %h", kind, a, b);
        if (n == 3 && kind == "I") begin
          if (a >= MEM_WORDS * 4) begin
            $display("program address %h lies outside the instruction memory", a);
            errors++;
          end else begin
            mem[a[7:2]] = b;
          end
        end else if (n == 3 && kind == "W") begin
          exp_rd.push_back(a[4:0]);
          exp_data.push_back(b);
        end
      end
    end
    $fclose(fd);
  endtask

  // Step on falling edges until halted rises.
  task automatic wait_for_halt();
    int cycles;
    cycles = 0;
    while (halted !== 1'b1 && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (halted !== 1'b1) begin
      $display("timed out after %0d cycles waiting for halted", HALT_TIMEOUT);
      errors++;
    end
  endtask

  // Writeback checker, sampled mid-cycle where outputs are settled.
  always @(negedge clk) begin
    reg_idx_t want_rd;
    word_t want_data;
    if (!reset && wb_valid) begin
      retired++;
      if (halted) begin
        $display("writeback to x%0d at %0t after the core halted", wb_rd, $time);
        errors++;
      end
      if (exp_rd.size() == 0) begin
        $display("writeback to x%0d at %0t with no expected entry left", wb_rd, $time);
        errors++;
      end else begin
        want_rd = exp_rd.pop_front();
        want_data = exp_data.pop_front();
        if (wb_rd !== want_rd || wb_data !== want_data) begin
          $display("mismatch at %0t: x%0d = %h, expected x%0d = %h",
                   $time, wb_rd, wb_data, want_rd, want_data);
          mismatches++;
        end
      end
    end
  end

  initial begin
    reset = 1'b1;
    imem_inst = '0;
    retired = 0;
    mismatches = 0;
    errors = 0;
    fill_memory();
    load_vectors();
    expected_total = exp_rd.size();
    if (expected_total == 0) begin
      $display("the vectors file holds no expected writebacks");
      errors++;
    end
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    wait_for_halt();
    // Give a stray writeback after the halt time to show up.
    repeat (DRAIN_CYCLES) @(negedge clk);
    if (exp_rd.size() != 0) begin
      $display("%0d expected writebacks never happened, next is x%0d",
               exp_rd.size(), exp_rd[0]);
      errors++;
    end
    $display("writebacks %0d of %0d expected, %0d mismatches, %0d other errors",
             retired, expected_total, mismatches, errors);
    if (mismatches == 0 && errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- design/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  output addr_t    imem_addr,
  input  inst_t    imem_inst,
  output logic     wb_valid,
  output reg_idx_t wb_rd,
  output word_t    wb_data,
  output logic     halted
);

  addr_t s3_pc;
  addr_t override_pc;
  logic [1:0] s1_pc_sel;
  decoded_t s1_dec;
  logic s1_kill;
  logic s2_kill;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t rs1_data;
  word_t rs2_data;
  ex_result_t s2_res;
  ex_result_t s3_res;
  logic s3_redirect;
  logic s3_halt;

  // s1, fetch and decode.
  // The s1 pc travels inside s1_dec.
  fetch_decode_stage fetch_decode_stage_inst (
    .clk(clk),
    .reset(reset),
    .s1_imem_addr(imem_addr),
    .s1_pc(),
    .s3_pc(s3_pc),
    .override_pc(override_pc),
    .s1_pc_sel(s1_pc_sel),
    .s1_inst(imem_inst),
    .s1_dec(s1_dec)
  );

  // Written from s3, read in s2.
  register_file register_file_inst (
    .clk(clk),
    .reset(reset),
    .rs1(rs1),
    .rs2(rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .we(wb_valid),
    .rd(wb_rd),
    .rd_data(wb_data)
  );

  // s2, operand read and execute.
  execute_stage execute_stage_inst (
    .clk(clk),
    .reset(reset),
    .s1_dec(s1_dec),
    .s1_kill(s1_kill),
    .rs1(rs1),
    .rs2(rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .s3_res(s3_res),
    .s2_res(s2_res)
  );

  // s3, writeback and redirect.
  writeback_stage writeback_stage_inst (
    .clk(clk),
    .reset(reset),
    .s2_res(s2_res),
    .s2_kill(s2_kill),
    .s3_res(s3_res),
    .wb_valid(wb_valid),
    .wb_rd(wb_rd),
    .wb_data(wb_data),
    .s3_pc(s3_pc),
    .s3_redirect(s3_redirect),
    .s3_halt(s3_halt)
  );

  pipeline_control pipeline_control_inst (
    .clk(clk),
    .reset(reset),
    .s1_dec(s1_dec),
    .s3_redirect(s3_redirect),
    .s3_halt(s3_halt),
    .s1_pc_sel(s1_pc_sel),
    .override_pc(override_pc),
    .s1_kill(s1_kill),
    .s2_kill(s2_kill),
    .halted(halted)
  );

endmodule

//--- design/pipeline_control.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module pipeline_control import cpu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  decoded_t   s1_dec,
  input  logic       s3_redirect,
  input  logic       s3_halt,
  output logic [1:0] s1_pc_sel,
  output addr_t      override_pc,
  output logic       s1_kill,
  output logic       s2_kill,
  output logic       halted
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  // First cycle after reset, no word has been read yet.
  logic first_q;
  addr_t jal_off;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ctrl_run;
      first_q <= 1'b1;
    end else begin
      state_q <= state_d;
      first_q <= 1'b0;
    end
  end

  assign halted = (state_q == ctrl_halted);

  // J-type offset, target computed in s1.
  assign jal_off = {{11{s1_dec.imm_uj[19]}}, s1_dec.imm_uj[19], s1_dec.imm_uj[7:0],
                    s1_dec.imm_uj[8], s1_dec.imm_uj[18:9], 1'b0};
  assign override_pc = s1_dec.pc + jal_off;

  // Priority: stall, s3 redirect, JAL, sequential.
  always_comb begin
    state_d = state_q;
    s1_pc_sel = `S1_PC_SEL_PLUS4;
    s1_kill = 1'b0;
    s2_kill = 1'b0;
    if (halted || first_q) begin
      // Hold the address so the word at pc is fetched.
      s1_pc_sel = `S1_PC_SEL_STALL;
      s1_kill = 1'b1;
    end else if (s3_redirect || s3_halt) begin
      s1_pc_sel = `S1_PC_SEL_S3;
      s1_kill = 1'b1;
      s2_kill = 1'b1;
      if (s3_halt) begin
        state_d = ctrl_halted;
      end
    end else if (s1_dec.opcode == `OPC_JAL) begin
      s1_pc_sel = `S1_PC_SEL_OVERRIDE;
    end
  end

  // Only reset leaves the halted state.
  halt_sticky: assert property (@(posedge clk) $fell(halted) |-> $past(reset));

endmodule

//--- design/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage import cpu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  ex_result_t s2_res,
  input  logic       s2_kill,
  output ex_result_t s3_res,
  output logic       wb_valid,
  output reg_idx_t   wb_rd,
  output word_t      wb_data,
  output addr_t      s3_pc,
  output logic       s3_redirect,
  output logic       s3_halt
);

  ex_result_t s3_q;

  // s3 pipeline register.
  // A kill drops every side effect of the entry.
  always_ff @(posedge clk) begin
    s3_q <= s2_res;
    if (reset || s2_kill) begin
      s3_q.valid <= 1'b0;
      s3_q.we <= 1'b0;
      s3_q.branch_taken <= 1'b0;
      s3_q.halt <= 1'b0;
    end
  end

  assign s3_res = s3_q;

  // Register write port and the retire strobe.
  assign wb_valid = s3_q.valid && s3_q.we;
  assign wb_rd = s3_q.rd;
  assign wb_data = s3_q.result;

  // Redirect requests to the controller.
  assign s3_pc = s3_q.target;
  assign s3_redirect = s3_q.valid && s3_q.branch_taken;
  assign s3_halt = s3_q.valid && s3_q.halt;

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module execute_stage import cpu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  decoded_t   s1_dec,
  input  logic       s1_kill,
  output reg_idx_t   rs1,
  output reg_idx_t   rs2,
  input  word_t      rs1_data,
  input  word_t      rs2_data,
  input  ex_result_t s3_res,
  output ex_result_t s2_res
);

  decoded_t s2_dec;
  logic s2_valid;
  word_t op_a;
  word_t op_b;
  word_t imm_ext;
  word_t alu_out;
  word_t result;
  addr_t branch_off;
  logic [4:0] shamt;
  logic is_sub;
  logic cond;
  logic writes_rd;
  logic is_ecall;

  // s2 pipeline register.
  always_ff @(posedge clk) begin
    s2_dec <= s1_dec;
    if (reset) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= !s1_kill;
    end
  end

  // Register reads happen in s2.
  assign rs1 = s2_dec.rs1;
  assign rs2 = s2_dec.rs2;

  // Forward the s3 result on a match with a nonzero destination.
  assign op_a = (s3_res.valid && s3_res.we && s3_res.rd != '0 && s3_res.rd == rs1) ?
                s3_res.result : rs1_data;
  assign op_b = (s3_res.valid && s3_res.we && s3_res.rd != '0 && s3_res.rd == rs2) ?
                s3_res.result : rs2_data;

  // Second ALU operand is the register or the sign-extended I-immediate.
  assign imm_ext = (s2_dec.opcode == `OPC_OP) ? op_b :
                   {{20{s2_dec.imm_i[11]}}, s2_dec.imm_i};
  assign shamt = imm_ext[4:0];
  // Bit 30 means SUB only for register ops.
  assign is_sub = (s2_dec.opcode == `OPC_OP) && s2_dec.add_rshift_type;

  always_comb begin
    case (s2_dec.func)
      `FN_ADD: alu_out = is_sub ? op_a - imm_ext : op_a + imm_ext;
      `FN_SLL: alu_out = op_a << shamt;
      `FN_SLT: alu_out = {31'b0, $signed(op_a) < $signed(imm_ext)};
      `FN_XOR: alu_out = op_a ^ imm_ext;
      // Arithmetic shift keeps the sign.
      `FN_SR:  alu_out = s2_dec.add_rshift_type ? word_t'($signed(op_a) >>> shamt) :
                         op_a >> shamt;
      `FN_OR:  alu_out = op_a | imm_ext;
      `FN_AND: alu_out = op_a & imm_ext;
      default: alu_out = '0;
    endcase
  end

  // Result mux by opcode.
  always_comb begin
    case (s2_dec.opcode)
      `OPC_LUI: result = {s2_dec.imm_uj, 12'b0};
      // Link address.
      `OPC_JAL: result = s2_dec.pc + 32'd4;
      default:  result = alu_out;
    endcase
  end

  // Branch compare on the forwarded operands.
  always_comb begin
    case (s2_dec.func)
      `FN_BEQ: cond = (op_a == op_b);
      `FN_BNE: cond = (op_a != op_b);
      `FN_BLT: cond = ($signed(op_a) < $signed(op_b));
      default: cond = 1'b0;
    endcase
  end

  // B-type offset rebuilt from the split immediate.
  assign branch_off = {{19{s2_dec.imm_bs[11]}}, s2_dec.imm_bs[11], s2_dec.imm_bs[0],
                       s2_dec.imm_bs[10:5], s2_dec.imm_bs[4:1], 1'b0};

  assign writes_rd = (s2_dec.opcode == `OPC_OP) || (s2_dec.opcode == `OPC_OP_IMM) ||
                     (s2_dec.opcode == `OPC_LUI) || (s2_dec.opcode == `OPC_JAL);
  assign is_ecall = (s2_dec.opcode == `OPC_SYSTEM) && (s2_dec.func == 3'b000) &&
                    (s2_dec.imm_i == 12'h000);

  always_comb begin
    s2_res.valid = s2_valid;
    s2_res.rd = s2_dec.rd;
    s2_res.we = s2_valid && writes_rd && (s2_dec.rd != '0);
    s2_res.result = result;
    s2_res.branch_taken = s2_valid && (s2_dec.opcode == `OPC_BRANCH) && cond;
    // A halt parks the pc on the ECALL itself.
    s2_res.target = is_ecall ? s2_dec.pc : s2_dec.pc + branch_off;
    s2_res.halt = s2_valid && is_ecall;
  end

  // A taken branch that reaches s3 is always a valid one, killed or not.
  no_taken_on_invalid: assert property (@(posedge clk) disable iff (reset)
    s3_res.branch_taken |-> s3_res.valid);

endmodule

//--- design/register_file.sv
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  logic     we,
  input  reg_idx_t rd,
  input  word_t    rd_data
);

  // x1 to x31; x0 has no storage.
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // Reads see a write of the same cycle.
  assign rs1_data = (rs1 == '0) ? '0 : (we && rd == rs1) ? rd_data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : (we && rd == rs2) ? rd_data : regs[rs2];

  // A write aimed at x0 leaves later reads of x0 at zero.
  x0_stays_zero: assert property (@(posedge clk) disable iff (reset)
    (we && rd == '0) ##1 (rs1 == '0 || rs2 == '0) |->
      ((rs1 != '0 || rs1_data == '0) && (rs2 != '0 || rs2_data == '0)));

endmodule

//--- design/fetch_decode_stage.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetch_decode_stage import cpu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  // Address sent to instruction memory, read back one cycle later.
  output addr_t      s1_imem_addr,
  // Address of the word now on s1_inst.
  output addr_t      s1_pc,
  input  addr_t      s3_pc,
  input  addr_t      override_pc,
  input  logic [1:0] s1_pc_sel,
  input  inst_t      s1_inst,
  output decoded_t   s1_dec
);

  addr_t pc;
  addr_t next_pc;

  // Next-pc mux.
  always_comb begin
    case (s1_pc_sel)
      `S1_PC_SEL_OVERRIDE: next_pc = override_pc;
      `S1_PC_SEL_S3:       next_pc = s3_pc;
      // Holding the address refetches the same word.
      `S1_PC_SEL_STALL:    next_pc = pc;
      default:             next_pc = pc + 32'd4;
    endcase
  end

  assign s1_imem_addr = next_pc;

  // The pc lags the memory address by the read latency.
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

  assign s1_pc = pc;

  // Slice the fetched word into its fields.
  always_comb begin
    s1_dec.pc = pc;
    s1_dec.rs1 = s1_inst[19:15];
    s1_dec.rs2 = s1_inst[24:20];
    s1_dec.rd = s1_inst[11:7];
    s1_dec.imm_i = s1_inst[31:20];
    s1_dec.imm_uj = s1_inst[31:12];
    s1_dec.imm_bs = {s1_inst[31:25], s1_inst[11:7]};
    s1_dec.opcode = s1_inst[6:0];
    s1_dec.func = s1_inst[14:12];
    s1_dec.add_rshift_type = s1_inst[30];
  end

endmodule

//--- design/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

  // Widths that carry a meaning in the core.
  typedef logic [`CPU_ADDR_BITS-1:0] addr_t;
  typedef logic [`CPU_INST_BITS-1:0] inst_t;
  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;

  // Fields of one instruction as sliced in s1.
  typedef struct packed {
    addr_t pc;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    // I-type immediate, inst[31:20].
    logic [11:0] imm_i;
    // U and J immediate bits, inst[31:12].
    logic [19:0] imm_uj;
    // B and S immediate bits, {inst[31:25], inst[11:7]}.
    logic [11:0] imm_bs;
    opcode_t opcode;
    funct3_t func;
    // Selects SUB and SRA, inst[30].
    logic add_rshift_type;
  } decoded_t;

  // What s2 hands to s3.
  typedef struct packed {
    logic valid;
    reg_idx_t rd;
    logic we;
    word_t result;
    logic branch_taken;
    addr_t target;
    logic halt;
  } ex_result_t;

  // Controller state.
  typedef enum logic {
    ctrl_run,
    ctrl_halted
  } ctrl_state_e;

endpackage

//--- design/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Address and instruction widths.
`define CPU_ADDR_BITS 32
`define CPU_INST_BITS 32

// Next-pc select codes driven by the controller.
`define S1_PC_SEL_PLUS4    2'd0
`define S1_PC_SEL_OVERRIDE 2'd1
`define S1_PC_SEL_S3       2'd2
`define S1_PC_SEL_STALL    2'd3

// Major opcodes of the supported RV32I subset.
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_JAL    7'b1101111
`define OPC_BRANCH 7'b1100011
`define OPC_SYSTEM 7'b1110011

// ALU funct3 values.
`define FN_ADD 3'b000
`define FN_SLL 3'b001
`define FN_SLT 3'b010
`define FN_XOR 3'b100
`define FN_SR  3'b101
`define FN_OR  3'b110
`define FN_AND 3'b111

// Branch funct3 values.
`define FN_BEQ 3'b000
`define FN_BNE 3'b001
`define FN_BLT 3'b100

`endif
